// ==== hw/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

   // Geometry of the cache
   localparam int ADDR_W  = 10;              // Word address, no byte offset
   localparam int DATA_W  = 32;              // Front-end and back-end word
   localparam int NBYTES  = DATA_W / 8;      // Bytes per word, one strobe each
   localparam int INDEX_W = 4;               // Set index bits
   localparam int NSETS   = 2 ** INDEX_W;    // 16 sets
   localparam int TAG_W   = ADDR_W - INDEX_W;
   localparam int NWAYS   = 2;               // One LRU bit per set covers two ways

   // Statistics
   localparam int CNT_W   = 16;

   // Vectors that carry a meaning
   typedef logic [ADDR_W-1:0]  addr_t;       // Word address
   typedef logic [TAG_W-1:0]   tag_t;        // Upper address bits kept per line
   typedef logic [INDEX_W-1:0] index_t;      // Lower address bits, selects the set
   typedef logic [DATA_W-1:0]  data_t;
   typedef logic [NBYTES-1:0]  strb_t;       // Nonzero means write
   typedef logic [CNT_W-1:0]   cnt_t;
   typedef logic [NWAYS-1:0]   way_sel_t;    // One-hot way enable

endpackage

// ==== hw/cache_bus_pkg.sv ====
package cache_bus_pkg;

   import cache_cfg_pkg::*;

   // Host request as held by the front end
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      strb_t wstrb;    // Zero for a read
   } fe_req_t;

   // Memory side request, same layout as the host one
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      strb_t wstrb;    // Zero for a refill read
   } be_req_t;

   // Per-way answer, valid the cycle after the index is presented
   typedef struct packed {
      logic  hit;
      data_t rdata;
   } lookup_t;

   // Whole-line write after a refill
   typedef struct packed {
      index_t index;
      tag_t   tag;
      data_t  data;
   } fill_t;

   // Byte-strobed write into a line that hit
   typedef struct packed {
      index_t index;
      data_t  wdata;
      strb_t  wstrb;
   } update_t;

   // Single-cycle statistics events
   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } hit_evt_t;

endpackage

// ==== hw/cache_front_end.sv ====
`timescale 1ns/10ps

module cache_front_end
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   // Host side
   input  logic     req,
   input  fe_req_t  fe_req,
   output logic     ack,
   output data_t    rdata,
   // Way lookup
   output index_t   lookup_index,
   output tag_t     lookup_tag,
   input  logic     hit,
   input  way_sel_t hit_way,
   input  data_t    hit_rdata,
   input  way_sel_t victim_way,
   // Way writes and LRU
   output way_sel_t fill_en,
   output fill_t    fill,
   output way_sel_t update_en,
   output update_t  update,
   output logic     touch,
   output way_sel_t touch_way,
   // Back end
   output logic     be_start,
   output be_req_t  be_out,
   input  logic     be_done,
   input  data_t    be_data,
   // Statistics
   output hit_evt_t evt
);

   typedef enum logic [1:0] {idle, lookup, refill, write_thru} fe_state_t;

   fe_state_t state;
   fe_req_t   req_q;         // Accepted request, held until ack
   way_sel_t  victim_q;      // Way chosen for the refill
   data_t     rdata_q;       // Hit data for the registered ack
   logic      ack_q;         // Read hit ack
   logic      accept;
   logic      is_write;
   logic      be_wait;

   assign accept   = (state == idle) && req && !ack_q;  // Host still holds req during ack
   assign is_write = |req_q.wstrb;
   assign be_wait  = (state == refill) || (state == write_thru);

   // Arrays read synchronously, so the index comes straight from the host while idle
   assign lookup_index = (state == idle) ? fe_req.addr[INDEX_W-1:0] : req_q.addr[INDEX_W-1:0];
   assign lookup_tag   = req_q.addr[ADDR_W-1:INDEX_W];

   // Hits ack from a register, memory accesses ack with be_done
   assign ack   = ack_q | (be_wait && be_done);
   assign rdata = ack_q ? rdata_q : be_data;

   assign fill   = '{index: req_q.addr[INDEX_W-1:0], tag: lookup_tag, data: be_data};
   assign update = '{index: req_q.addr[INDEX_W-1:0], wdata: req_q.wdata, wstrb: req_q.wstrb};
   assign be_out = '{addr: req_q.addr, wdata: req_q.wdata, wstrb: req_q.wstrb};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= idle;
         ack_q <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         case (state)
            idle: if (accept) state <= lookup;
            lookup: begin
               if (is_write) begin
                  state <= write_thru;               // Hit or miss, memory gets it
               end else if (hit) begin
                  ack_q <= 1'b1;
                  state <= idle;
               end else begin
                  state <= refill;
               end
            end
            default: if (be_done) state <= idle;   // Stall here on a slow be_ack
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) req_q <= fe_req;
      if (state == lookup) begin
         victim_q <= victim_way;                   // Frozen for the whole refill
         rdata_q  <= hit_rdata;
      end
   end

   always_comb begin
      fill_en   = '0;
      update_en = '0;
      touch     = 1'b0;
      touch_way = hit_way;
      be_start  = 1'b0;
      evt       = '0;
      case (state)
         lookup: begin
            if (is_write) begin
               be_start = 1'b1;                    // Write-through always
               if (hit) begin
                  update_en     = hit_way;         // Only the strobed bytes change
                  touch         = 1'b1;
                  evt.write_hit = 1'b1;
               end else begin
                  evt.write_miss = 1'b1;           // No allocate
               end
            end else if (hit) begin
               touch        = 1'b1;
               evt.read_hit = 1'b1;
            end else begin
               be_start      = 1'b1;               // Refill read, strobe is zero
               evt.read_miss = 1'b1;
            end
         end
         refill: begin
            if (be_done) begin
               fill_en   = victim_q;
               touch     = 1'b1;
               touch_way = victim_q;
            end
         end
         default: ;
      endcase
   end

endmodule

// ==== hw/cache_way.sv ====
`timescale 1ns/10ps

module cache_way
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    invalidate,
   input  index_t  lookup_index,
   input  tag_t    lookup_tag,
   input  logic    fill_en,
   input  fill_t   fill,
   input  logic    update_en,
   input  update_t update,
   output lookup_t result
);

   tag_t             tag_mem  [NSETS];
   data_t            data_mem [NSETS];
   logic [NSETS-1:0] valid;
   tag_t             tag_q;     // Registered array outputs
   data_t            data_q;
   logic             valid_q;

   // Tag compare on the registered line
   assign result = '{hit: valid_q && (tag_q == lookup_tag), rdata: data_q};

   always_ff @(posedge clk) begin
      tag_q  <= tag_mem[lookup_index];
      data_q <= data_mem[lookup_index];
      if (fill_en) begin
         tag_mem[fill.index]  <= fill.tag;
         data_mem[fill.index] <= fill.data;
      end else if (update_en) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (update.wstrb[b]) data_mem[update.index][8*b +: 8] <= update.wdata[8*b +: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid   <= '0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= valid[lookup_index];
         if (fill_en) valid[fill.index] <= 1'b1;
         if (invalidate) valid <= '0;              // Wins over a fill in the same cycle
      end
   end

endmodule

// ==== hw/cache_way_select.sv ====
`timescale 1ns/10ps

module cache_way_select
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      invalidate,
   input  index_t                    lookup_index,
   input  lookup_t [NWAYS-1:0]       results,
   input  logic                      touch,
   input  way_sel_t                  touch_way,
   output logic                      hit,
   output way_sel_t                  hit_way,
   output data_t                     hit_rdata,
   output way_sel_t                  victim_way
);

   logic [NSETS-1:0] lru;    // Per set, the way to evict next

   // Reduce the way results
   always_comb begin
      hit       = 1'b0;
      hit_rdata = '0;
      for (int w = 0; w < NWAYS; w++) begin
         hit_way[w] = results[w].hit;
         if (results[w].hit) begin
            hit       = 1'b1;
            hit_rdata = results[w].rdata;          // At most one way hits
         end
      end
   end

   // One-hot victim of the current set
   always_comb begin
      victim_way = '0;
      victim_way[lru[lookup_index]] = 1'b1;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lru <= '0;
      end else if (invalidate) begin
         lru <= '0;
      end else if (touch) begin
         lru[lookup_index] <= touch_way[0];        // Point at the way not touched
      end
   end

endmodule

// ==== hw/cache_back_end.sv ====
`timescale 1ns/10ps

module cache_back_end
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   // Front end command
   input  logic    be_start,
   input  be_req_t be_cmd,
   output logic    be_done,
   output data_t   be_data,
   // Memory port
   output logic    be_req,
   output be_req_t be_out,
   input  data_t   be_rdata,
   input  logic    be_ack
);

   logic hs;     // Memory handshake

   assign hs = be_req && be_ack;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         be_req  <= 1'b0;
         be_done <= 1'b0;
      end else begin
         be_done <= hs;                            // Same cycle be_req drops
         if (be_start) be_req <= 1'b1;
         else if (hs) be_req <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (be_start) be_out <= be_cmd;              // Held stable until be_ack
      if (hs) be_data <= be_rdata;
   end

endmodule

// ==== hw/cache_control.sv ====
`timescale 1ns/10ps

module cache_control
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  hit_evt_t evt,
   input  logic     cnt_clear,
   output cnt_t     read_hit_cnt,
   output cnt_t     read_miss_cnt,
   output cnt_t     write_hit_cnt,
   output cnt_t     write_miss_cnt
);

   logic [3:0] evt_v;     // Same bit order as hit_evt_t
   cnt_t       cnt [4];

   assign evt_v = evt;

   always_ff @(posedge clk) begin
      if (!rst_n || cnt_clear) begin
         for (int i = 0; i < 4; i++) cnt[i] <= '0;
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (evt_v[i] && (cnt[i] != '1)) cnt[i] <= cnt[i] + 1'b1;  // Saturate
         end
      end
   end

   assign read_hit_cnt   = cnt[3];
   assign read_miss_cnt  = cnt[2];
   assign write_hit_cnt  = cnt[1];
   assign write_miss_cnt = cnt[0];

endmodule

// ==== hw/cache_top.sv ====
`timescale 1ns/10ps

module cache_top
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   // Host bus
   input  logic    req,
   input  fe_req_t fe_req,
   output data_t   rdata,
   output logic    ack,
   // Memory bus
   output logic    be_req,
   output be_req_t be_out,
   input  data_t   be_rdata,
   input  logic    be_ack,
   // Control
   input  logic    invalidate,    // Level, clears all lines
   input  logic    cnt_clear,
   output cnt_t    read_hit_cnt,
   output cnt_t    read_miss_cnt,
   output cnt_t    write_hit_cnt,
   output cnt_t    write_miss_cnt
);

   index_t              lookup_index;
   tag_t                lookup_tag;
   lookup_t [NWAYS-1:0] results;
   logic                hit;
   way_sel_t            hit_way, victim_way, fill_en, update_en, touch_way;
   data_t               hit_rdata, be_data;
   fill_t               fill;
   update_t             update;
   logic                touch, be_start, be_done;
   be_req_t             be_cmd;
   hit_evt_t            evt;

   cache_front_end front_end (
      .clk, .rst_n, .req, .fe_req, .ack, .rdata,
      .lookup_index, .lookup_tag, .hit, .hit_way, .hit_rdata, .victim_way,
      .fill_en, .fill, .update_en, .update, .touch, .touch_way,
      .be_start, .be_out (be_cmd), .be_done, .be_data, .evt
   );

   // Identical ways, each sees the same lookup and its own enables
   for (genvar w = 0; w < NWAYS; w++) begin : g_way
      cache_way way (
         .clk, .rst_n, .invalidate, .lookup_index, .lookup_tag,
         .fill_en   (fill_en[w]),
         .fill,
         .update_en (update_en[w]),
         .update,
         .result    (results[w])
      );
   end

   cache_way_select way_select (
      .clk, .rst_n, .invalidate, .lookup_index, .results, .touch, .touch_way,
      .hit, .hit_way, .hit_rdata, .victim_way
   );

   cache_back_end back_end (
      .clk, .rst_n, .be_start, .be_cmd, .be_done, .be_data,
      .be_req, .be_out, .be_rdata, .be_ack
   );

   cache_control control (
      .clk, .rst_n, .evt, .cnt_clear,
      .read_hit_cnt, .read_miss_cnt, .write_hit_cnt, .write_miss_cnt
   );

endmodule

// ==== testbench/cache_tb_model.svh ====
// Reference model of memory, tags, valid bits, LRU and counters

data_t  model_mem [1 << ADDR_W];
tag_t   m_tag     [NSETS][NWAYS];
logic   m_valid   [NSETS][NWAYS];
int     m_lru     [NSETS];            // Way to evict next
int     n_rh, n_rm, n_wh, n_wm;       // Expected counts

// Initial memory word, every address bit shows up
function automatic data_t fill_word(input addr_t a);
   return {6'h2a, a, 6'h15, a};
endfunction

// Way holding the address, or -1
function automatic int model_find(input addr_t a);
   for (int w = 0; w < NWAYS; w++) begin
      if (m_valid[a[INDEX_W-1:0]][w] && m_tag[a[INDEX_W-1:0]][w] == a[ADDR_W-1:INDEX_W]) return w;
   end
   return -1;
endfunction

task automatic model_invalidate();
   for (int i = 0; i < NSETS; i++) begin
      m_lru[i] = 0;
      for (int w = 0; w < NWAYS; w++) m_valid[i][w] = 1'b0;
   end
endtask

task automatic model_init();
   for (int a = 0; a < (1 << ADDR_W); a++) model_mem[a] = fill_word(addr_t'(a));
   model_invalidate();
   n_rh = 0;
   n_rm = 0;
   n_wh = 0;
   n_wm = 0;
endtask

// Replay one access, two-way LRU, no write-allocate
task automatic model_access(input addr_t a, input strb_t s, input data_t d);
   int     w;
   index_t idx;
   w   = model_find(a);
   idx = a[INDEX_W-1:0];
   if (|s) begin
      for (int b = 0; b < NBYTES; b++) if (s[b]) model_mem[a][8*b +: 8] = d[8*b +: 8];
      if (w >= 0) begin
         n_wh++;
         m_lru[idx] = 1 - w;
      end else n_wm++;                                // Line left alone
   end else if (w >= 0) begin
      n_rh++;
      m_lru[idx] = 1 - w;
   end else begin
      w = m_lru[idx];                                 // Victim gets the refill
      m_tag[idx][w]   = a[ADDR_W-1:INDEX_W];
      m_valid[idx][w] = 1'b1;
      m_lru[idx]      = 1 - w;
      n_rm++;
   end
endtask

// ==== testbench/cache_tb.sv ====
`timescale 1ns/10ps

module cache_tb
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;
;

   localparam int N_RAND     = 400;
   localparam int MAX_CYCLES = (N_RAND + 12) * 8 + 200;   // 8 cycles per access at most

   logic    clk, rst_n, req, ack, be_req, be_ack, invalidate, cnt_clear;
   fe_req_t fe_req;
   be_req_t be_out, exp_be;
   data_t   rdata, be_rdata;
   cnt_t    read_hit_cnt, read_miss_cnt, write_hit_cnt, write_miss_cnt;
   data_t   mem [1 << ADDR_W];       // Responder memory
   int      seed = 32'h9e94;
   int      cyc = 0;
   int      be_ack_cyc;              // Cycle in which be_ack was driven
   logic    be_expected = 1'b0;
   logic    saw_be;
   int      err_data = 0, err_be = 0, err_cnt = 0, err_other = 0;

   `include "cache_tb_model.svh"

   cache_top UUT (
      .clk, .rst_n, .req, .fe_req, .rdata, .ack, .be_req, .be_out, .be_rdata, .be_ack,
      .invalidate, .cnt_clear, .read_hit_cnt, .read_miss_cnt, .write_hit_cnt, .write_miss_cnt
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Cycle count and run limit
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc > MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp) begin
         err_data++;
         $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic check_be(input string name, input be_req_t exp, input be_req_t act);
      if (act !== exp) begin
         err_be++;
         $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic check_cnt(input string name, input cnt_t exp, input cnt_t act);
      if (act !== exp) begin
         err_cnt++;
         $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act);
      end
   endtask

   // Memory responder with 1 to 4 cycles of delay
   initial begin
      int delay;
      forever begin
         @(negedge clk);
         if (be_req === 1'b1) begin
            if (be_expected) check_be("be_out", exp_be, be_out);
            else begin
               err_other++;
               $display("Memory request at %0t that the model did not expect", $time);
            end
            be_expected = 1'b0;
            saw_be      = 1'b1;
            delay = 1 + ($unsigned($random(seed)) % 4);
            repeat (delay) @(posedge clk);
            #5;
            be_ack     = 1'b1;
            be_ack_cyc = cyc;
            be_rdata   = mem[be_out.addr];
            for (int b = 0; b < NBYTES; b++) begin
               if (be_out.wstrb[b]) mem[be_out.addr][8*b +: 8] = be_out.wdata[8*b +: 8];
            end
            @(posedge clk);
            #5 be_ack = 1'b0;
         end
      end
   end

   // One host access that starts and ends 5 ns after a rising edge
   task automatic do_access(input addr_t a, input strb_t s, input data_t d);
      logic  exp_miss;
      data_t exp_rd;
      int    drive_cyc;
      exp_miss    = model_find(a) < 0;
      exp_rd      = model_mem[a];
      exp_be      = '{addr: a, wdata: d, wstrb: s};
      be_expected = (|s) || exp_miss;
      saw_be      = 1'b0;
      req         = 1'b1;
      fe_req      = '{addr: a, wdata: d, wstrb: s};
      drive_cyc   = cyc;
      do @(negedge clk); while (ack !== 1'b1);
      if (!(|s)) check_data("rdata", exp_rd, rdata);
      if (!(|s) && !exp_miss) begin
         if (cyc - drive_cyc != 2) begin
            err_other++;
            $display("Read hit at %0t acked after %0d cycles, not 2", $time, cyc - drive_cyc);
         end
      end else if (cyc != be_ack_cyc + 1) begin
         err_other++;
         $display("Ack at %0t did not follow be_ack by one cycle", $time);
      end
      if (be_expected && !saw_be) begin
         err_other++;
         $display("No memory request seen for address %h at %0t", a, $time);
      end
      model_access(a, s, d);
      @(posedge clk);
      #5 req = 1'b0;
   endtask

   initial begin
      int    r;
      addr_t a;
      strb_t s;
      data_t d;
      addr_t cached [$];
      rst_n      = 1'b0;
      req        = 1'b0;
      fe_req     = '0;
      be_rdata   = '0;
      be_ack     = 1'b0;
      invalidate = 1'b0;
      cnt_clear  = 1'b0;
      for (int i = 0; i < (1 << ADDR_W); i++) mem[i] = fill_word(addr_t'(i));
      model_init();
      repeat (8) @(posedge clk);
      #5 rst_n = 1'b1;
      if (ack !== 1'b0 || be_req !== 1'b0) begin
         err_other++;
         $display("ack or be_req not low after reset");
      end
      check_cnt("read_hit_cnt", '0, read_hit_cnt);
      check_cnt("read_miss_cnt", '0, read_miss_cnt);
      check_cnt("write_hit_cnt", '0, write_hit_cnt);
      check_cnt("write_miss_cnt", '0, write_miss_cnt);

      // Three tags in set 9 evict the first one and its reread must miss
      for (int k = 0; k < 4; k++) do_access(addr_t'({tag_t'(k % 3), index_t'(9)}), '0, '0);

      // Narrow pool of two sets with four tags each
      for (int i = 0; i < N_RAND; i++) begin
         r = $random(seed);
         a = addr_t'({tag_t'(r[1:0]), r[2] ? index_t'(5) : index_t'(12)});
         s = (r[4:3] == 2'd0) ? strb_t'(r[8:5]) : '0;   // About a quarter are writes
         if (r[4:3] == 2'd0 && s == '0) s = '1;
         d = $random(seed);
         do_access(a, s, d);
      end

      // Everything cached must miss after invalidate
      for (int k = 0; k < (1 << ADDR_W); k++) begin
         if (model_find(addr_t'(k)) >= 0) cached.push_back(addr_t'(k));
      end
      invalidate = 1'b1;
      @(posedge clk);
      #5 invalidate = 1'b0;
      model_invalidate();
      foreach (cached[j]) do_access(cached[j], '0, '0);

      repeat (2) @(posedge clk);
      check_cnt("read_hit_cnt", cnt_t'(n_rh), read_hit_cnt);
      check_cnt("read_miss_cnt", cnt_t'(n_rm), read_miss_cnt);
      check_cnt("write_hit_cnt", cnt_t'(n_wh), write_hit_cnt);
      check_cnt("write_miss_cnt", cnt_t'(n_wm), write_miss_cnt);
      cnt_clear = 1'b1;
      @(posedge clk);
      #5 cnt_clear = 1'b0;
      check_cnt("read_hit_cnt", '0, read_hit_cnt);
      check_cnt("read_miss_cnt", '0, read_miss_cnt);
      check_cnt("write_hit_cnt", '0, write_hit_cnt);
      check_cnt("write_miss_cnt", '0, write_miss_cnt);

      $display("Errors: %0d data, %0d be, %0d cnt, %0d other",
               err_data, err_be, err_cnt, err_other);
      if (err_data + err_be + err_cnt + err_other == 0) $display("ALL TESTS PASSED");
      else $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+testbench
hw/cache_cfg_pkg.sv
hw/cache_bus_pkg.sv
hw/cache_front_end.sv
hw/cache_way.sv
hw/cache_way_select.sv
hw/cache_back_end.sv
hw/cache_control.sv
hw/cache_top.sv
testbench/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator and run the cache testbench

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

if ! verilator --binary --timing -f sim.f --top-module cache_tb -o cache_sim; then
   echo "Verilator compile failed"
   exit 1
fi

if ! ./obj_dir/cache_sim > sim.log 2>&1; then
   cat sim.log
   echo "Simulation exited with an error"
   exit 1
fi

cat sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
   exit 1
fi
exit 0
